// ==== common/cpuPkg.sv ====
package cpuPkg;

	localparam int INSTR_W = 16;
	localparam int DATA_W = 16;
	localparam int REG_COUNT = 16;
	localparam int REG_ADDR_W = $clog2(REG_COUNT);
	localparam int RAM_ADDR_W = 8;
	localparam int PC_W = 8;
	localparam int FLAG_W = 5;
	localparam int IMM_W = 8;

	// flag bit positions
	localparam int FLAG_C = 0; // carry or borrow
	localparam int FLAG_L = 1; // unsigned below
	localparam int FLAG_F = 2; // signed overflow
	localparam int FLAG_Z = 3;
	localparam int FLAG_N = 4; // signed below

	localparam logic [3:0] EXT_LOAD = 4'h0;
	localparam logic [3:0] EXT_STOR = 4'h4;

	typedef enum logic [3:0] {
		sFetch,
		sDecode,
		sReadReg,
		sExecReg,
		sExecImm,
		sMemAddr,
		sLoadRead,
		sLoadWrite,
		sStore,
		sDone
	} cpuState_e;

	typedef enum logic [3:0] {
		ADD  = 4'd0,
		SUB  = 4'd1,
		CMP  = 4'd2,
		AND  = 4'd3,
		OR   = 4'd4,
		XOR  = 4'd5,
		NOT  = 4'd6,
		LSH  = 4'd7,
		RSH  = 4'd8,
		ARSH = 4'd9,
		MUL  = 4'd10
	} aluOp_e;

	// codes 8, 12, 13 and 15 are left unnamed and decode as NOP
	typedef enum logic [3:0] {
		REGOP = 4'd0,
		ANDI  = 4'd1,
		ORI   = 4'd2,
		XORI  = 4'd3,
		MEMOP = 4'd4,
		ADDI  = 4'd5,
		ADDUI = 4'd6,
		ADDCI = 4'd7,
		SUBI  = 4'd9,
		SUBCI = 4'd10,
		CMPI  = 4'd11,
		MULI  = 4'd14
	} majorOp_e;

	typedef struct packed {
		logic pcEn;
		logic regWrite;
		logic ramWrite;
		logic flagWrite;
		logic immSel; // immediate as second operand
		logic signedImm;
		logic ramAddrSel; // latch memory address
		logic loadSel; // memory data to writeback
		aluOp_e aluOp;
		logic [REG_ADDR_W-1:0] rdest;
		logic [REG_ADDR_W-1:0] rsrc;
		logic [IMM_W-1:0] imm;
	} ctrl_t;

	typedef struct packed {
		logic en;
		logic [REG_ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
	} wb_t;

	typedef struct packed {
		logic en;
		logic [RAM_ADDR_W-1:0] addr;
		logic [DATA_W-1:0] data;
	} store_t;

endpackage

// ==== logic/alu.sv ====
`timescale 1ns/1ps

module alu (
	input cpuPkg::aluOp_e aluOp,
	input logic [cpuPkg::DATA_W-1:0] a,
	input logic [cpuPkg::DATA_W-1:0] b,
	output logic [cpuPkg::DATA_W-1:0] result,
	output logic [cpuPkg::FLAG_W-1:0] flagsOut
);

	logic [cpuPkg::DATA_W:0] sum;
	logic [cpuPkg::DATA_W:0] diff;
	logic [cpuPkg::DATA_W-1:0] prod;
	logic [3:0] shamt;
	logic isAdd;
	logic isSub;

	assign sum = {1'b0, a} + {1'b0, b};
	assign diff = {1'b0, a} - {1'b0, b}; // msb is the borrow
	assign prod = a * b; // low half only
	assign shamt = b[3:0];
	assign isAdd = (aluOp == cpuPkg::ADD);
	assign isSub = (aluOp == cpuPkg::SUB) || (aluOp == cpuPkg::CMP);

	always_comb begin
		case (aluOp)
			cpuPkg::ADD: result = sum[cpuPkg::DATA_W-1:0];
			cpuPkg::SUB, cpuPkg::CMP: result = diff[cpuPkg::DATA_W-1:0];
			cpuPkg::AND: result = a & b;
			cpuPkg::OR: result = a | b;
			cpuPkg::XOR: result = a ^ b;
			cpuPkg::NOT: result = ~a;
			cpuPkg::LSH: result = a << shamt;
			cpuPkg::RSH: result = a >> shamt;
			cpuPkg::ARSH: result = $signed(a) >>> shamt;
			cpuPkg::MUL: result = prod;
			default: result = '0;
		endcase
	end

	always_comb begin
		flagsOut = '0;
		if (isAdd)
			flagsOut[cpuPkg::FLAG_C] = sum[cpuPkg::DATA_W];
		else if (isSub)
			flagsOut[cpuPkg::FLAG_C] = diff[cpuPkg::DATA_W];
		flagsOut[cpuPkg::FLAG_L] = (a < b);
		// sign of result disagrees with operands
		if (isAdd)
			flagsOut[cpuPkg::FLAG_F] = (a[cpuPkg::DATA_W-1] == b[cpuPkg::DATA_W-1]) &&
				(sum[cpuPkg::DATA_W-1] != a[cpuPkg::DATA_W-1]);
		else if (isSub)
			flagsOut[cpuPkg::FLAG_F] = (a[cpuPkg::DATA_W-1] != b[cpuPkg::DATA_W-1]) &&
				(diff[cpuPkg::DATA_W-1] != a[cpuPkg::DATA_W-1]);
		flagsOut[cpuPkg::FLAG_Z] = (result == '0); // a == b on cmp
		flagsOut[cpuPkg::FLAG_N] = ($signed(a) < $signed(b));
	end

endmodule

// ==== logic/regFile.sv ====
`timescale 1ns/1ps

module regFile (
	input logic Clk,
	input logic rst,
	input cpuPkg::wb_t wb,
	input logic [cpuPkg::REG_ADDR_W-1:0] rsrc,
	input logic [cpuPkg::REG_ADDR_W-1:0] rdest,
	output logic [cpuPkg::DATA_W-1:0] srcData,
	output logic [cpuPkg::DATA_W-1:0] destData
);

	logic [cpuPkg::DATA_W-1:0] regs [cpuPkg::REG_COUNT];

	always_ff @(posedge Clk) begin
		if (rst) begin
			for (int i = 0; i < cpuPkg::REG_COUNT; i++)
				regs[i] <= '0;
		end else if (wb.en) begin
			regs[wb.addr] <= wb.data;
		end
	end

	assign srcData = regs[rsrc];
	assign destData = regs[rdest]; // first operand and store data

endmodule

// ==== logic/dataRam.sv ====
`timescale 1ns/1ps

module dataRam (
	input logic Clk,
	input cpuPkg::store_t store,
	input logic [cpuPkg::RAM_ADDR_W-1:0] readAddr,
	output logic [cpuPkg::DATA_W-1:0] readData
);

	localparam int DEPTH = 2 ** cpuPkg::RAM_ADDR_W;

	logic [cpuPkg::DATA_W-1:0] mem [DEPTH];

	initial begin
		for (int i = 0; i < DEPTH; i++)
			mem[i] = '0;
	end

	always_ff @(posedge Clk) begin
		if (store.en)
			mem[store.addr] <= store.data;
	end

	assign readData = mem[readAddr]; // async read

endmodule

// ==== logic/datapath.sv ====
`timescale 1ns/1ps

module datapath (
	input logic Clk,
	input logic rst,
	input cpuPkg::ctrl_t ctrl,
	input logic [cpuPkg::DATA_W-1:0] ramData,
	output logic [cpuPkg::PC_W-1:0] pc,
	output logic [cpuPkg::FLAG_W-1:0] flags,
	output cpuPkg::wb_t wb,
	output cpuPkg::store_t store
);

	logic [cpuPkg::DATA_W-1:0] srcData;
	logic [cpuPkg::DATA_W-1:0] destData;
	logic [cpuPkg::DATA_W-1:0] immExt;
	logic [cpuPkg::DATA_W-1:0] aluB;
	logic [cpuPkg::DATA_W-1:0] aluResult;
	logic [cpuPkg::FLAG_W-1:0] aluFlags;
	logic [cpuPkg::RAM_ADDR_W-1:0] memAddr;
	logic [cpuPkg::DATA_W-1:0] memData;

	always_ff @(posedge Clk) begin
		if (rst) begin
			pc <= '0;
			flags <= '0;
		end else begin
			if (ctrl.pcEn)
				pc <= pc + cpuPkg::PC_W'(1);
			if (ctrl.flagWrite)
				flags <= aluFlags;
		end
	end

	// address and read data held across the memory cycles
	always_ff @(posedge Clk) begin
		if (ctrl.ramAddrSel)
			memAddr <= srcData[cpuPkg::RAM_ADDR_W-1:0];
		if (ctrl.loadSel)
			memData <= ramData;
	end

	assign immExt = ctrl.signedImm ?
		{{(cpuPkg::DATA_W-cpuPkg::IMM_W){ctrl.imm[cpuPkg::IMM_W-1]}}, ctrl.imm} :
		{{(cpuPkg::DATA_W-cpuPkg::IMM_W){1'b0}}, ctrl.imm};
	assign aluB = ctrl.immSel ? immExt : srcData;

	regFile regFile_inst (
		.Clk(Clk),
		.rst(rst),
		.wb(wb),
		.rsrc(ctrl.rsrc),
		.rdest(ctrl.rdest),
		.srcData(srcData),
		.destData(destData)
	);

	alu alu_inst (
		.aluOp(ctrl.aluOp),
		.a(destData),
		.b(aluB),
		.result(aluResult),
		.flagsOut(aluFlags)
	);

	assign wb.en = ctrl.regWrite;
	assign wb.addr = ctrl.rdest;
	assign wb.data = ctrl.loadSel ? memData : aluResult;

	assign store.en = ctrl.ramWrite;
	assign store.addr = memAddr;
	assign store.data = destData; // stor writes rdest

endmodule

// ==== control/controlFsm.sv ====
`timescale 1ns/1ps

module controlFsm (
	input logic Clk,
	input logic rst,
	input logic [cpuPkg::INSTR_W-1:0] instr,
	output cpuPkg::ctrl_t ctrl
);

	cpuPkg::cpuState_e state;
	cpuPkg::cpuState_e nextState;
	logic [cpuPkg::INSTR_W-1:0] ir;
	cpuPkg::majorOp_e major;
	logic [3:0] ext;

	// register group extended codes reuse the major encoding
	function automatic cpuPkg::aluOp_e opFor(input logic [3:0] code);
		case (cpuPkg::majorOp_e'(code))
			cpuPkg::ADDI, cpuPkg::ADDUI, cpuPkg::ADDCI: return cpuPkg::ADD;
			cpuPkg::SUBI, cpuPkg::SUBCI: return cpuPkg::SUB;
			cpuPkg::CMPI: return cpuPkg::CMP;
			cpuPkg::ANDI: return cpuPkg::AND;
			cpuPkg::ORI: return cpuPkg::OR;
			cpuPkg::XORI: return cpuPkg::XOR;
			cpuPkg::MULI: return cpuPkg::MUL;
			default: return cpuPkg::LSH;
		endcase
	endfunction

	function automatic logic isNopExt(input logic [3:0] code);
		return code inside {4'd0, 4'd4, 4'd8, 4'd12, 4'd13, 4'd15};
	endfunction

	function automatic logic isImmOp(input cpuPkg::majorOp_e op);
		return op inside {cpuPkg::ANDI, cpuPkg::ORI, cpuPkg::XORI, cpuPkg::ADDI,
			cpuPkg::ADDUI, cpuPkg::ADDCI, cpuPkg::SUBI, cpuPkg::SUBCI,
			cpuPkg::CMPI, cpuPkg::MULI};
	endfunction

	assign major = cpuPkg::majorOp_e'(ir[15:12]);
	assign ext = ir[7:4];

	always_ff @(posedge Clk) begin
		if (rst)
			state <= cpuPkg::sFetch;
		else
			state <= nextState;
	end

	always_ff @(posedge Clk) begin
		if (state == cpuPkg::sFetch)
			ir <= instr;
	end

	always_comb begin
		nextState = cpuPkg::sFetch;
		case (state)
			cpuPkg::sFetch: nextState = cpuPkg::sDecode;
			cpuPkg::sDecode: begin
				if (major == cpuPkg::REGOP)
					nextState = isNopExt(ext) ? cpuPkg::sFetch : cpuPkg::sReadReg;
				else if (isImmOp(major))
					nextState = cpuPkg::sExecImm;
				else if (major == cpuPkg::MEMOP &&
						(ext == cpuPkg::EXT_LOAD || ext == cpuPkg::EXT_STOR))
					nextState = cpuPkg::sMemAddr;
			end
			cpuPkg::sReadReg: nextState = cpuPkg::sExecReg;
			cpuPkg::sMemAddr: begin
				if (ext == cpuPkg::EXT_LOAD)
					nextState = cpuPkg::sLoadRead;
				else
					nextState = cpuPkg::sStore;
			end
			cpuPkg::sLoadRead: nextState = cpuPkg::sLoadWrite;
			cpuPkg::sStore: nextState = cpuPkg::sDone;
			default: nextState = cpuPkg::sFetch; // exec, writeback, done
		endcase
	end

	always_comb begin
		ctrl = '0;
		ctrl.aluOp = cpuPkg::ADD;
		ctrl.rdest = ir[11:8];
		ctrl.rsrc = ir[3:0];
		ctrl.imm = ir[7:0];
		case (state)
			cpuPkg::sFetch: ctrl.pcEn = 1'b1;
			cpuPkg::sReadReg: ctrl.aluOp = opFor(ext);
			cpuPkg::sExecReg: begin
				ctrl.aluOp = opFor(ext);
				ctrl.flagWrite = 1'b1;
				ctrl.regWrite = (opFor(ext) != cpuPkg::CMP); // cmp only sets flags
			end
			cpuPkg::sExecImm: begin
				ctrl.aluOp = opFor(ir[15:12]);
				ctrl.immSel = 1'b1;
				ctrl.signedImm = (major != cpuPkg::ADDUI);
				ctrl.flagWrite = 1'b1;
				ctrl.regWrite = (major != cpuPkg::CMPI);
			end
			cpuPkg::sMemAddr: ctrl.ramAddrSel = 1'b1;
			cpuPkg::sLoadRead: ctrl.loadSel = 1'b1;
			cpuPkg::sLoadWrite: begin
				ctrl.loadSel = 1'b1;
				ctrl.regWrite = 1'b1;
			end
			cpuPkg::sStore: ctrl.ramWrite = 1'b1;
			default: ctrl.pcEn = 1'b0; // decode and done drive no strobes
		endcase
	end

endmodule

// ==== logic/cpuTop.sv ====
`timescale 1ns/1ps

module cpuTop (
	input logic Clk,
	input logic rst,
	input logic [cpuPkg::INSTR_W-1:0] instr,
	output logic [cpuPkg::PC_W-1:0] pc,
	output logic [cpuPkg::FLAG_W-1:0] flags,
	output cpuPkg::wb_t wb,
	output cpuPkg::store_t store
);

	cpuPkg::ctrl_t ctrl;
	logic [cpuPkg::DATA_W-1:0] ramData;

	controlFsm controlFsm_inst (
		.Clk(Clk),
		.rst(rst),
		.instr(instr),
		.ctrl(ctrl)
	);

	datapath datapath_inst (
		.Clk(Clk),
		.rst(rst),
		.ctrl(ctrl),
		.ramData(ramData),
		.pc(pc),
		.flags(flags),
		.wb(wb),
		.store(store)
	);

	// read address follows the latched store address
	dataRam dataRam_inst (
		.Clk(Clk),
		.store(store),
		.readAddr(store.addr),
		.readData(ramData)
	);

endmodule

// ==== tests/cpuChk.sv ====
`timescale 1ns/1ps

module cpuChk (
	input logic Clk,
	input logic rst,
	input cpuPkg::cpuState_e state,
	input cpuPkg::ctrl_t ctrl
);

	logic [2:0] sinceFetch; // cycles spent away from fetch

	always_ff @(posedge Clk) begin
		if (rst || state == cpuPkg::sFetch)
			sinceFetch <= '0;
		else
			sinceFetch <= sinceFetch + 3'd1;
	end

	fetchAfterReset: assert property (@(posedge Clk) rst |=> state == cpuPkg::sFetch)
		else $error("FSM is not in fetch after reset");

	pcEnInFetch: assert property (@(posedge Clk) disable iff (rst)
		ctrl.pcEn |-> state == cpuPkg::sFetch)
		else $error("pc enable outside fetch");

	oneWriteStrobe: assert property (@(posedge Clk) disable iff (rst)
		!(ctrl.regWrite && ctrl.ramWrite))
		else $error("register and memory write strobes high together");

	backToFetch: assert property (@(posedge Clk) disable iff (rst) sinceFetch < 3'd6)
		else $error("FSM did not return to fetch within 6 cycles");

endmodule

bind controlFsm cpuChk cpuChk_inst (
	.Clk(Clk),
	.rst(rst),
	.state(state),
	.ctrl(ctrl)
);

// ==== tests/cpuTb.sv ====
`timescale 1ns/1ps

module cpuTb;

	localparam int PROG_DEPTH = 2 ** cpuPkg::PC_W;
	localparam int RUN_LIMIT = 2000; // cycles allowed to reach program end

	typedef struct packed {
		logic [7:0] kind;
		logic [7:0] addr;
		logic [15:0] data;
	} expEvent_t;

	logic Clk;
	logic rst;
	logic [cpuPkg::INSTR_W-1:0] instr;
	logic [cpuPkg::PC_W-1:0] pc;
	logic [cpuPkg::FLAG_W-1:0] flags;
	cpuPkg::wb_t wb;
	cpuPkg::store_t store;

	logic [cpuPkg::INSTR_W-1:0] prog [PROG_DEPTH];
	expEvent_t expected [$];
	logic [cpuPkg::FLAG_W-1:0] expFlags;
	logic haveFlags;
	int lastAddr;
	int errorCount;
	int checkCount;
	int eventCount;

	cpuTop cpuTop_inst (
		.Clk(Clk),
		.rst(rst),
		.instr(instr),
		.pc(pc),
		.flags(flags),
		.wb(wb),
		.store(store)
	);

	initial begin
		Clk = 1'b0;
		forever #20 Clk = ~Clk;
	end

	// instruction memory model
	always @(posedge Clk)
		instr <= prog[pc];

	task automatic checkValue(input string name, input logic [31:0] expValue,
			input logic [31:0] actValue);
		checkCount++;
		if (actValue !== expValue) begin
			errorCount++;
			$display("Error %s expected %0h actual %0h", name, expValue, actValue);
		end
	endtask

	function automatic string eventName(input logic [7:0] kind);
		if (kind == "W")
			return "writeback";
		return "store";
	endfunction

	task automatic matchEvent(input logic [7:0] kind, input logic [7:0] addr,
			input logic [15:0] data);
		expEvent_t ev;
		eventCount++;
		if (expected.size() == 0) begin
			errorCount++;
			$display("Unexpected %s to address %0h with data %0h", eventName(kind), addr, data);
		end else begin
			ev = expected.pop_front();
			if (ev.kind != kind) begin
				errorCount++;
				$display("Event %0d is a %s but a %s was expected", eventCount,
					eventName(kind), eventName(ev.kind));
			end else begin
				checkValue($sformatf("%s %0d address", eventName(kind), eventCount),
					32'(ev.addr), 32'(addr));
				checkValue($sformatf("%s %0d data", eventName(kind), eventCount),
					32'(ev.data), 32'(data));
			end
		end
	endtask

	task automatic loadVectors();
		int fd;
		int code;
		int ch;
		logic [7:0] kind;
		logic [15:0] addr;
		logic [15:0] data;
		expEvent_t ev;
		fd = $fopen("tests/cpuVectors.txt", "r");
		if (fd == 0) begin
			errorCount++;
			$display("Could not open the vector file tests/cpuVectors.txt");
			return;
		end
		while (!$feof(fd)) begin
			code = $fscanf(fd, " %c", kind);
			if (code != 1)
				break;
			if (kind == "#") begin // comment runs to end of line
				ch = $fgetc(fd);
				while (ch != 10 && ch != -1)
					ch = $fgetc(fd);
			end else begin
				code = $fscanf(fd, " %h %h", addr, data);
				if (code != 2) begin
					errorCount++;
					$display("Vector line of kind %c has no address and data", kind);
					break;
				end
				if (kind == "P") begin
					prog[addr[7:0]] = data;
					if (int'(addr) > lastAddr)
						lastAddr = int'(addr);
				end else if (kind == "F") begin
					expFlags = data[cpuPkg::FLAG_W-1:0];
					haveFlags = 1'b1;
				end else begin
					ev.kind = kind;
					ev.addr = addr[7:0];
					ev.data = data;
					expected.push_back(ev);
				end
			end
		end
		$fclose(fd);
	endtask

	// write events are stable away from the rising edge
	always @(negedge Clk) begin
		if (rst) begin
			if (wb.en || store.en) begin
				errorCount++;
				$display("A write event occurred while reset was high");
			end
		end else if (wb.en) begin
			matchEvent("W", {4'h0, wb.addr}, wb.data);
		end else if (store.en) begin
			matchEvent("S", store.addr, store.data);
		end
	end

	initial begin
		int cycles;
		expEvent_t ev;
		rst = 1'b1;
		instr = '0;
		errorCount = 0;
		checkCount = 0;
		eventCount = 0;
		lastAddr = -1;
		haveFlags = 1'b0;
		expFlags = '0;
		// unused words hold major opcode 8, a NOP, tagged with their address
		for (int i = 0; i < PROG_DEPTH; i++)
			prog[i] = 16'h8000 | 16'(i);
		loadVectors();
		repeat (4) @(posedge Clk);
		rst <= 1'b0;
		@(negedge Clk);
		checkValue("pc after reset", 32'd0, 32'(pc));
		checkValue("flags after reset", 32'd0, 32'(flags));
		cycles = 0;
		// pc past lastAddr + 1 means the last word has retired
		while (int'(pc) < lastAddr + 2 && cycles < RUN_LIMIT) begin
			@(negedge Clk);
			cycles++;
		end
		if (cycles >= RUN_LIMIT) begin
			errorCount++;
			$display("Timed out waiting for the program counter to pass the last program word");
		end else if (haveFlags) begin
			checkValue("final flags", 32'(expFlags), 32'(flags));
		end
		while (expected.size() > 0) begin
			ev = expected.pop_front();
			errorCount++;
			$display("Missing %s to address %0h", eventName(ev.kind), ev.addr);
		end
		$display("Checks run %0d, errors %0d", checkCount, errorCount);
		if (errorCount == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

// ==== tests/cpuVectors.txt ====
# kind addr data, hex; P program word, W register write (reg, value)
# S store (address, value), F final flags {N, Z, F, L, C}
P 00 5112
W 01 0012
P 01 52FD
W 02 FFFD
P 02 63FD
W 03 00FD
P 03 5407
W 04 0007
P 04 0154
W 01 0019
P 05 0294
W 02 FFF6
P 06 0312
W 03 00F4
P 07 0421
W 04 001F
P 08 0133
W 01 00ED
P 09 04E4
W 04 03C1
P 0A 0000
P 0B 93FE
W 03 00F6
P 0C 12F0
W 02 FFF0
P 0D 5540
W 05 0040
P 0E 4445
S 40 03C1
P 0F 4605
W 06 03C1
P 10 01F2
P 11 B105
P 12 06B2
F 00 0003

// ==== project.f ====
common/cpuPkg.sv
logic/alu.sv
logic/regFile.sv
logic/dataRam.sv
logic/datapath.sv
control/controlFsm.sv
logic/cpuTop.sv
tests/cpuChk.sv
tests/cpuTb.sv

// ==== Makefile ====
obj_dir/VcpuTb: project.f $(shell cat project.f) tests/cpuVectors.txt
	verilator --binary --timing --assert --top-module cpuTb -f project.f -o VcpuTb

run: obj_dir/VcpuTb
	./obj_dir/VcpuTb > sim.log 2>&1; cat sim.log
	grep -q "All checks passed" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: run clean
